// ==== verilog/duc_pkg.sv ====
// ==========================================================
// DUC shared definitions
// Datapath widths, settings-bus addresses, the settings
// word layout and the interpolation rate limits
// ==========================================================

package duc_pkg;

   // Datapath widths
   localparam int BB_W    = 16;               // one baseband component
   localparam int DSP_W   = 18;               // baseband plus two fraction bits
   localparam int OUT_W   = 24;               // front-end word
   localparam int SCALE_W = 18;
   localparam int PROD_W  = DSP_W + SCALE_W;  // full gain product
   localparam int SET_W   = 32;

   // Gain of 1 << SCALE_SHIFT passes samples unchanged
   localparam int SCALE_SHIFT = 10;
   localparam logic signed [SCALE_W-1:0] SCALE_UNITY = SCALE_W'(1 << SCALE_SHIFT);

   // Interpolation rate is 2**rate_log2, at most 16
   localparam int RATE_LOG2_W   = 3;
   localparam int MAX_RATE_LOG2 = 4;

   // CIC growth is up to 2**MAX_RATE_LOG2, two more bits for the combs
   localparam int CIC_W = DSP_W + MAX_RATE_LOG2 + 2;

   // Settings-bus register map
   localparam logic [7:0] SR_PHASE_INC = 8'd0;
   localparam logic [7:0] SR_SCALE     = 8'd1;
   localparam logic [7:0] SR_RATE      = 8'd2;

   typedef struct packed {
      logic [SET_W-RATE_LOG2_W-1:0] reserved;
      logic [RATE_LOG2_W-1:0]       rate_log2;
   } rate_cfg_t;

   // One settings data word, seen either whole or as a rate word
   typedef union packed {
      logic [SET_W-1:0] raw;
      rate_cfg_t        rate_cfg;
   } settings_word_u;

endpackage

// ==== verilog/duc_cfg_if.sv ====
// ==========================================================
// DUC configuration bus
// Decoded settings from the settings block to every
// datapath stage
// ==========================================================

interface duc_cfg_if;

   logic [31:0]                             phase_inc;   // NCO step per clock
   logic signed [duc_pkg::SCALE_W-1:0]      scale;
   logic [duc_pkg::RATE_LOG2_W-1:0]         rate_log2;
   logic                                    rate_change; // One cycle after a rate write

   modport cfg_src (
      output phase_inc,
      output scale,
      output rate_log2,
      output rate_change
   );

   // Each stage picks what it needs
   modport cfg_dst (
      input phase_inc,
      input scale,
      input rate_log2,
      input rate_change
   );

endinterface

// ==== verilog/duc_settings.sv ====
// ==========================================================
// DUC settings decoder
// Turns settings-bus writes into the registered phase
// increment, gain and rate, and flags rate changes
// ==========================================================

module duc_settings (
   input  logic        clk,
   input  logic        rst,
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   duc_cfg_if.cfg_src  cfg
);

   duc_pkg::settings_word_u                 set_word;
   logic [31:0]                             phase_inc_r;
   logic signed [duc_pkg::SCALE_W-1:0]      scale_r;
   logic [duc_pkg::RATE_LOG2_W-1:0]         rate_r;
   logic [duc_pkg::RATE_LOG2_W-1:0]         rate_clamped;
   logic                                    rate_chg_r;

   assign set_word = set_data_i;

   // Anything above 16x is held at 16x
   always_comb begin
      if (set_word.rate_cfg.rate_log2 > duc_pkg::RATE_LOG2_W'(duc_pkg::MAX_RATE_LOG2))
         rate_clamped = duc_pkg::RATE_LOG2_W'(duc_pkg::MAX_RATE_LOG2);
      else
         rate_clamped = set_word.rate_cfg.rate_log2;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         phase_inc_r <= '0;
         scale_r     <= duc_pkg::SCALE_UNITY;   // Unity gain
         rate_r      <= '0;                     // No interpolation
         rate_chg_r  <= 1'b0;
      end else begin
         rate_chg_r <= 1'b0;
         if (set_stb_i) begin
            case (set_addr_i)
               duc_pkg::SR_PHASE_INC: phase_inc_r <= set_word.raw;
               duc_pkg::SR_SCALE:     scale_r <= set_word.raw[duc_pkg::SCALE_W-1:0];
               duc_pkg::SR_RATE: begin
                  rate_r     <= rate_clamped;
                  rate_chg_r <= 1'b1;           // Restarts strober and CIC
               end
               default: ;
            endcase
         end
      end
   end

   assign cfg.phase_inc   = phase_inc_r;
   assign cfg.scale       = scale_r;
   assign cfg.rate_log2   = rate_r;
   assign cfg.rate_change = rate_chg_r;

endmodule

// ==== verilog/interp_strober.sv ====
// ==========================================================
// Interpolation strober
// Requests one baseband sample every 2**rate_log2 clocks
// ==========================================================

module interp_strober (
   input  logic       clk,
   input  logic       rst,
   input  logic       run_i,
   duc_cfg_if.cfg_dst cfg,
   output logic       strobe_o
);

   logic [duc_pkg::MAX_RATE_LOG2-1:0] cnt;
   logic [duc_pkg::MAX_RATE_LOG2:0]   period;
   logic [duc_pkg::MAX_RATE_LOG2-1:0] last;
   logic                              active;

   // Rate is clamped to 16 so the period always fits
   assign period = (duc_pkg::MAX_RATE_LOG2 + 1)'(1) << cfg.rate_log2;
   assign last   = duc_pkg::MAX_RATE_LOG2'(period - 1'b1);
   assign active = run_i & ~cfg.rate_change;

   always_ff @(posedge clk) begin
      if (rst || !active)
         cnt <= '0;                 // Restart from a fresh period
      else if (cnt == last)
         cnt <= '0;
      else
         cnt <= cnt + 1'b1;
   end

   assign strobe_o = active && (cnt == '0);

endmodule

// ==== verilog/cic_interp.sv ====
// ==========================================================
// Second-order CIC interpolator
// Two combs at the sample rate, two integrators at the
// clock rate, for I and Q, normalised back to unity gain
// ==========================================================

module cic_interp (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run_i,
   input  logic                              stb_i,
   input  logic signed [duc_pkg::DSP_W-1:0]  i_i,
   input  logic signed [duc_pkg::DSP_W-1:0]  q_i,
   duc_cfg_if.cfg_dst                        cfg,
   output logic signed [duc_pkg::DSP_W-1:0]  i_o,
   output logic signed [duc_pkg::DSP_W-1:0]  q_o
);

   // Index 0 is I, index 1 is Q
   logic signed [duc_pkg::CIC_W-1:0] din    [2];
   logic signed [duc_pkg::CIC_W-1:0] x_d    [2];   // Previous sample
   logic signed [duc_pkg::CIC_W-1:0] c1_d   [2];   // Previous first difference
   logic signed [duc_pkg::CIC_W-1:0] comb_r [2];
   logic signed [duc_pkg::CIC_W-1:0] integ1 [2];
   logic signed [duc_pkg::CIC_W-1:0] integ2 [2];
   logic signed [duc_pkg::CIC_W-1:0] norm   [2];
   logic                             comb_v;       // Comb output is fresh this cycle
   logic                             clear;

   assign din[0] = i_i;       // Sign extended into the guard bits
   assign din[1] = q_i;

   assign clear = rst | ~run_i | cfg.rate_change;

   always_ff @(posedge clk) begin
      if (clear) begin
         comb_v <= 1'b0;
         for (int ch = 0; ch < 2; ch++) begin
            x_d[ch]    <= '0;
            c1_d[ch]   <= '0;
            comb_r[ch] <= '0;
            integ1[ch] <= '0;
            integ2[ch] <= '0;
         end
      end else begin
         comb_v <= stb_i;
         for (int ch = 0; ch < 2; ch++) begin
            if (stb_i) begin
               x_d[ch]    <= din[ch];
               c1_d[ch]   <= din[ch] - x_d[ch];
               comb_r[ch] <= (din[ch] - x_d[ch]) - c1_d[ch];
            end
            // Zero stuffing between strobes
            integ1[ch] <= integ1[ch] + (comb_v ? comb_r[ch] : '0);
            integ2[ch] <= integ2[ch] + integ1[ch];
         end
      end
   end

   // Gain of the chain is the rate itself, so a plain shift undoes it
   always_comb begin
      for (int ch = 0; ch < 2; ch++)
         norm[ch] = integ2[ch] >>> cfg.rate_log2;
   end

   assign i_o = norm[0][duc_pkg::DSP_W-1:0];
   assign q_o = norm[1][duc_pkg::DSP_W-1:0];

endmodule

// ==== verilog/quadrant_rotator.sv ====
// ==========================================================
// Quadrant rotator
// Phase accumulator whose top two bits turn the I/Q
// stream in quarter steps
// ==========================================================

module quadrant_rotator (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run_i,
   duc_cfg_if.cfg_dst                        cfg,
   input  logic signed [duc_pkg::DSP_W-1:0]  i_i,
   input  logic signed [duc_pkg::DSP_W-1:0]  q_i,
   output logic signed [duc_pkg::DSP_W-1:0]  i_o,
   output logic signed [duc_pkg::DSP_W-1:0]  q_o
);

   logic [31:0] phase;

   // Most negative value has no positive twin, so it pins to the top
   function automatic logic signed [duc_pkg::DSP_W-1:0] sat_neg(
      input logic signed [duc_pkg::DSP_W-1:0] v
   );
      if (v == {1'b1, {(duc_pkg::DSP_W-1){1'b0}}})
         return {1'b0, {(duc_pkg::DSP_W-1){1'b1}}};
      return -v;
   endfunction

   always_ff @(posedge clk) begin
      if (rst || !run_i)
         phase <= '0;
      else
         phase <= phase + cfg.phase_inc;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         i_o <= '0;
         q_o <= '0;
      end else begin
         case (phase[31:30])
            2'd0: begin i_o <= i_i;          q_o <= q_i;          end
            2'd1: begin i_o <= sat_neg(q_i); q_o <= i_i;          end  // +90 deg
            2'd2: begin i_o <= sat_neg(i_i); q_o <= sat_neg(q_i); end
            default: begin
               i_o <= q_i;                    // -90 deg
               q_o <= sat_neg(i_i);
            end
         endcase
      end
   end

endmodule

// ==== verilog/gain_scaler.sv ====
// ==========================================================
// Gain scaler
// Multiplies I/Q by the programmed gain, drops the
// fraction and clips to the front-end word width
// ==========================================================

module gain_scaler (
   input  logic                              clk,
   input  logic                              rst,
   duc_cfg_if.cfg_dst                        cfg,
   input  logic signed [duc_pkg::DSP_W-1:0]  i_i,
   input  logic signed [duc_pkg::DSP_W-1:0]  q_i,
   output logic [duc_pkg::OUT_W-1:0]         tx_i_o,
   output logic [duc_pkg::OUT_W-1:0]         tx_q_o
);

   logic signed [duc_pkg::PROD_W-1:0] prod_i;
   logic signed [duc_pkg::PROD_W-1:0] prod_q;

   // Shift then clip, rounding toward minus infinity
   function automatic logic [duc_pkg::OUT_W-1:0] scale_sat(
      input logic signed [duc_pkg::PROD_W-1:0] p
   );
      logic signed [duc_pkg::PROD_W-1:0] s;
      logic [duc_pkg::PROD_W-duc_pkg::OUT_W:0] hi;
      s  = p >>> duc_pkg::SCALE_SHIFT;
      hi = s[duc_pkg::PROD_W-1:duc_pkg::OUT_W-1];
      if (&hi || ~|hi)
         return s[duc_pkg::OUT_W-1:0];       // Fits as is
      else if (s[duc_pkg::PROD_W-1])
         return {1'b1, {(duc_pkg::OUT_W-1){1'b0}}};
      else
         return {1'b0, {(duc_pkg::OUT_W-1){1'b1}}};
   endfunction

   assign prod_i = i_i * cfg.scale;
   assign prod_q = q_i * cfg.scale;

   always_ff @(posedge clk) begin
      if (rst) begin
         tx_i_o <= '0;
         tx_q_o <= '0;
      end else begin
         tx_i_o <= scale_sat(prod_i);
         tx_q_o <= scale_sat(prod_q);
      end
   end

endmodule

// ==== verilog/duc_chain.sv ====
// ==========================================================
// DUC chain top level
// Settings decode, sample request, CIC interpolation,
// quadrant rotation and gain for one transmit channel
// ==========================================================

module duc_chain (
   input  logic        clk,
   input  logic        rst,
   // Settings bus
   input  logic        set_stb_i,
   input  logic [7:0]  set_addr_i,
   input  logic [31:0] set_data_i,
   // From TX control
   input  logic        run_i,
   input  logic [31:0] sample_i,
   output logic        strobe_o,
   // To TX front end
   output logic [23:0] tx_i_o,
   output logic [23:0] tx_q_o
);

   duc_cfg_if cfg_bus ();

   logic [31:0]                       bb_r;       // Held baseband word, I in the top half
   logic                              bb_stb;     // bb_r was just refreshed
   logic signed [duc_pkg::DSP_W-1:0]  bb_i;
   logic signed [duc_pkg::DSP_W-1:0]  bb_q;
   logic signed [duc_pkg::DSP_W-1:0]  cic_i;
   logic signed [duc_pkg::DSP_W-1:0]  cic_q;
   logic signed [duc_pkg::DSP_W-1:0]  rot_i;
   logic signed [duc_pkg::DSP_W-1:0]  rot_q;

   duc_settings u_settings (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .cfg        (cfg_bus.cfg_src)
   );

   interp_strober u_strober (
      .clk      (clk),
      .rst      (rst),
      .run_i    (run_i),
      .cfg      (cfg_bus.cfg_dst),
      .strobe_o (strobe_o)
   );

   // Sample stays put between requests
   always_ff @(posedge clk) begin
      if (strobe_o)
         bb_r <= sample_i;
   end

   always_ff @(posedge clk) begin
      if (rst)
         bb_stb <= 1'b0;
      else
         bb_stb <= strobe_o;
   end

   // Two zero fraction bits below each component
   assign bb_i = {bb_r[2*duc_pkg::BB_W-1 -: duc_pkg::BB_W],
                  {(duc_pkg::DSP_W-duc_pkg::BB_W){1'b0}}};
   assign bb_q = {bb_r[duc_pkg::BB_W-1:0], {(duc_pkg::DSP_W-duc_pkg::BB_W){1'b0}}};

   cic_interp u_cic (
      .clk   (clk),
      .rst   (rst),
      .run_i (run_i),
      .stb_i (bb_stb),
      .i_i   (bb_i),
      .q_i   (bb_q),
      .cfg   (cfg_bus.cfg_dst),
      .i_o   (cic_i),
      .q_o   (cic_q)
   );

   quadrant_rotator u_rotator (
      .clk   (clk),
      .rst   (rst),
      .run_i (run_i),
      .cfg   (cfg_bus.cfg_dst),
      .i_i   (cic_i),
      .q_i   (cic_q),
      .i_o   (rot_i),
      .q_o   (rot_q)
   );

   gain_scaler u_scaler (
      .clk    (clk),
      .rst    (rst),
      .cfg    (cfg_bus.cfg_dst),
      .i_i    (rot_i),
      .q_i    (rot_q),
      .tx_i_o (tx_i_o),
      .tx_q_o (tx_q_o)
   );

endmodule

// ==== tests/tb_clock.sv ====
// ==========================================================
// Testbench clock and reset
// Free-running clock of period 40 and a reset held for
// the first 5 rising edges
// ==========================================================

module tb_clock (
   output logic clk_o,
   output logic rst_o
);

   localparam int PERIOD     = 40;
   localparam int RST_CYCLES = 5;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      #2 rst_o = 1'b0;   // Same skew as the stimulus
   end

endmodule

// ==== tests/duc_tb.sv ====
// ==========================================================
// DUC chain testbench
// Drives settings, run and baseband samples into the chain
// and checks idle state, strobe rate, CIC gain, rotation
// and output scaling against reference rules
// ==========================================================

module duc_tb;

   localparam int CLK_PERIOD = 40;
   localparam int SETTLE     = 40;   // Settling cycles per unit of rate
   localparam int N_SAMPLES  = 3;
   localparam int STROBE_MAX = 64;
   // Upper bound of each test in cycles, summed for the watchdog
   localparam int RUN_CYCLES = 10 + 8 + N_SAMPLES * (SETTLE + 2)
                             + 6 * (3 * 16 + 4)
                             + 6 * (8 + N_SAMPLES * (SETTLE * 16 + 2))
                             + (8 + SETTLE + 12) + 8 * (8 + SETTLE + 2);
   localparam int LIMIT      = 2 * RUN_CYCLES + 500;

   logic        clk;
   logic        rst;
   logic        set_stb;
   logic [7:0]  set_addr;
   logic [31:0] set_data;
   logic        run;
   logic [31:0] sample;
   logic        strobe;
   logic [23:0] tx_i;
   logic [23:0] tx_q;

   int errors;
   int tests_passed;
   int tests_failed;
   int idle_cycles = 0;   // Clocks since run went low

   tb_clock u_clock (
      .clk_o (clk),
      .rst_o (rst)
   );

   duc_chain dut (
      .clk        (clk),
      .rst        (rst),
      .set_stb_i  (set_stb),
      .set_addr_i (set_addr),
      .set_data_i (set_data),
      .run_i      (run),
      .sample_i   (sample),
      .strobe_o   (strobe),
      .tx_i_o     (tx_i),
      .tx_q_o     (tx_q)
   );

   always @(posedge clk) begin
      if (rst || run)
         idle_cycles <= 0;
      else if (idle_cycles < 8)
         idle_cycles <= idle_cycles + 1;
   end

   no_strobe_idle: assert property (@(negedge clk) disable iff (rst) !run |-> !strobe)
   else begin
      $display("Mismatch at %0t: sample request while run is low", $time);
      errors = errors + 1;
   end

   // Three stages to flush once run drops
   zero_out_idle: assert property (@(negedge clk) disable iff (rst)
      idle_cycles >= 3 |-> (tx_i == '0 && tx_q == '0))
   else begin
      $display("Mismatch at %0t: idle outputs %h/%h", $time, tx_i, tx_q);
      errors = errors + 1;
   end

   // Component with two fraction bits, sign extended
   function automatic logic [23:0] unity_word(input logic [15:0] c);
      return {{6{c[15]}}, c, 2'b00};
   endfunction

   // Floor of value times gain over 1024, clipped to 24 bits
   function automatic logic [23:0] scaled_word(input logic [23:0] u, input int gain);
      longint p;
      p = longint'($signed(u)) * longint'(gain);
      p = p >>> 10;
      if (p > 64'sd8388607)
         p = 64'sd8388607;
      else if (p < -64'sd8388608)
         p = -64'sd8388608;
      return 24'(p);
   endfunction

   function automatic logic [23:0] negate(input logic [23:0] v);
      return -v;
   endfunction

   function automatic logic [47:0] quarter_turn(input logic [23:0] i, input logic [23:0] q);
      return {negate(q), i};
   endfunction

   // Full-scale negative does not return to itself after four turns
   function automatic logic [31:0] avoid_min(input logic [31:0] w);
      if (w[31:16] == 16'h8000)
         w[31:16] = 16'h8001;
      if (w[15:0] == 16'h8000)
         w[15:0] = 16'h8001;
      return w;
   endfunction

   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      step();
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      step();
      set_stb  = 1'b0;
   endtask

   // Clears CIC, phase and output pipeline
   task automatic go_idle();
      step();
      run = 1'b0;
      repeat (4) step();
   endtask

   task automatic settle(input int rate_log2);
      repeat (SETTLE << rate_log2) step();
   endtask

   task automatic check_tx(input logic [23:0] exp_i, input logic [23:0] exp_q,
                           input string what);
      @(negedge clk);
      assert (tx_i == exp_i && tx_q == exp_q)
      else begin
         $display("Mismatch at %0t: %s, got %h/%h, expected %h/%h",
                  $time, what, tx_i, tx_q, exp_i, exp_q);
         errors = errors + 1;
      end
      step();
   endtask

   task automatic wait_strobe(output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!strobe && cycles < STROBE_MAX);
      if (!strobe) begin
         $display("No sample request seen within %0d cycles at %0t", STROBE_MAX, $time);
         errors = errors + 1;
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      if (errors == err_start) begin
         tests_passed++;
         $display("PASS %s", name);
      end else begin
         tests_failed++;
         $display("FAIL %s with %0d errors", name, errors - err_start);
      end
   endtask

   initial begin
      #(LIMIT * CLK_PERIOD);
      $display("Timeout: tests still running after %0d clock cycles", LIMIT);
      $display("Verification failed");
      $finish;
   end

   initial begin
      int          e0;
      int          gap;
      int          rate;
      int          expect_gap;
      logic [47:0] prev;
      set_stb      = 1'b0;
      set_addr     = '0;
      set_data     = '0;
      run          = 1'b0;
      sample       = '0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      void'($urandom(50619));
      @(negedge rst);

      e0 = errors;
      repeat (8) begin
         @(negedge clk);
         assert (!strobe && tx_i == '0 && tx_q == '0)
         else begin
            $display("Mismatch at %0t: after reset strobe %b, outputs %h/%h",
                     $time, strobe, tx_i, tx_q);
            errors = errors + 1;
         end
      end
      finish_test("reset and idle", e0);

      // Default settings only
      e0 = errors;
      step();
      run = 1'b1;
      repeat (N_SAMPLES) begin
         sample = $urandom;
         settle(0);
         check_tx(unity_word(sample[31:16]), unity_word(sample[15:0]), "unity path");
      end
      finish_test("unity path", e0);

      e0 = errors;
      for (int k = 0; k < 6; k++) begin
         rate = (k == 5) ? 7 : k;   // 7 lands on the clamp
         expect_gap = 1 << ((rate > duc_pkg::MAX_RATE_LOG2) ? duc_pkg::MAX_RATE_LOG2 : rate);
         write_reg(duc_pkg::SR_RATE, 32'(rate));
         wait_strobe(gap);
         repeat (2) begin
            wait_strobe(gap);
            assert (gap == expect_gap)
            else begin
               $display("Mismatch at %0t: rate word %0d gives strobe spacing %0d, expected %0d",
                        $time, rate, gap, expect_gap);
               errors = errors + 1;
            end
         end
      end
      finish_test("strobe rate", e0);

      e0 = errors;
      // Last pass writes 7 and expects 16x
      for (int r = 0; r <= duc_pkg::MAX_RATE_LOG2 + 1; r++) begin
         rate = (r > duc_pkg::MAX_RATE_LOG2) ? 7 : r;
         go_idle();
         write_reg(duc_pkg::SR_RATE, 32'(rate));
         run = 1'b1;
         repeat (N_SAMPLES) begin
            sample = $urandom;
            settle((r > duc_pkg::MAX_RATE_LOG2) ? duc_pkg::MAX_RATE_LOG2 : r);
            check_tx(unity_word(sample[31:16]), unity_word(sample[15:0]),
                     $sformatf("CIC gain for rate word %0d", rate));
         end
      end
      write_reg(duc_pkg::SR_RATE, 32'd0);
      finish_test("interpolation gain", e0);

      // One quarter turn per clock
      e0 = errors;
      go_idle();
      write_reg(duc_pkg::SR_PHASE_INC, 32'h4000_0000);
      run = 1'b1;
      sample = avoid_min($urandom);
      settle(0);
      @(negedge clk);
      prev = {tx_i, tx_q};
      repeat (8) begin
         @(negedge clk);
         assert ({tx_i, tx_q} == quarter_turn(prev[47:24], prev[23:0]))
         else begin
            $display("Mismatch at %0t: %h/%h does not follow %h/%h by a quarter turn",
                     $time, tx_i, tx_q, prev[47:24], prev[23:0]);
            errors = errors + 1;
         end
         prev = {tx_i, tx_q};
      end
      go_idle();
      write_reg(duc_pkg::SR_PHASE_INC, 32'd0);
      finish_test("quadrant rotation", e0);

      e0 = errors;
      write_reg(duc_pkg::SR_SCALE, 32'd512);
      run = 1'b1;
      repeat (N_SAMPLES) begin
         sample = $urandom;
         settle(0);
         check_tx(scaled_word(unity_word(sample[31:16]), 512),
                  scaled_word(unity_word(sample[15:0]), 512), "half gain");
      end
      // Odd gain leaves a fraction that must round down
      write_reg(duc_pkg::SR_SCALE, 32'd3);
      repeat (N_SAMPLES) begin
         sample = $urandom;
         settle(0);
         check_tx(scaled_word(unity_word(sample[31:16]), 3),
                  scaled_word(unity_word(sample[15:0]), 3), "odd gain");
      end
      write_reg(duc_pkg::SR_SCALE, 32'd131071);
      sample = 32'h7FFF_8000;
      settle(0);
      check_tx(24'h7FFFFF, 24'h800000, "saturation, positive I");
      sample = 32'h8000_7FFF;
      settle(0);
      check_tx(24'h800000, 24'h7FFFFF, "saturation, negative I");
      finish_test("gain and saturation", e0);

      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// ==== sources.f ====
verilog/duc_pkg.sv
verilog/duc_cfg_if.sv
verilog/duc_settings.sv
verilog/interp_strober.sv
verilog/cic_interp.sv
verilog/quadrant_rotator.sv
verilog/gain_scaler.sv
verilog/duc_chain.sv
tests/tb_clock.sv
tests/duc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := duc_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Verification passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
